// ==== isa_pkg.sv ====
// instruction set definitions (field layout, widths, opcodes) used by decode and execute
package isa_pkg;

    localparam int DATA_W     = 16;
    localparam int REG_ADDR_W = 4;
    localparam int OP_W       = 4;

    // bit positions of the instruction fields
    localparam int OP_LSB  = 0;
    localparam int RD_LSB  = 4;
    localparam int RS1_LSB = 8;
    localparam int RS2_LSB = 12;

    // ADDI adds the signed 4-bit rs2 field to rs1
    // BEQZ offset is the signed 8-bit {rs2, rd} field, relative to its own address
    // LW and SW address the data memory with the low bits of rs1, SW stores rs2
    typedef enum logic [OP_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_SLT  = 4'd4,
        OP_ADDI = 4'd5,
        OP_LW   = 4'd6,
        OP_SW   = 4'd7,
        OP_IN   = 4'd8,
        OP_OUT  = 4'd9,
        OP_BEQZ = 4'd10,
        OP_HALT = 4'd11
    } opcode_e;

endpackage

// ==== pipe_pkg.sv ====
// pipeline internals shared by the stages: memory sizes, ALU operations, forwarding sources
package pipe_pkg;

    localparam int IMEM_DEPTH  = 64;
    localparam int IMEM_ADDR_W = 6;
    localparam int DMEM_DEPTH  = 16;
    localparam int DMEM_ADDR_W = 4;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

endpackage

// ==== register_file.sv ====
// 16-entry register file read in decode and written from writeback, with same-cycle bypass
module register_file (
    input  logic                             clock,
    input  logic                             rst_n,
    input  logic [isa_pkg::REG_ADDR_W-1:0]   rs1_addr,
    input  logic [isa_pkg::REG_ADDR_W-1:0]   rs2_addr,
    input  logic                             wb_we,
    input  logic [isa_pkg::REG_ADDR_W-1:0]   wb_rd,
    input  logic [isa_pkg::DATA_W-1:0]       wb_data,
    output logic [isa_pkg::DATA_W-1:0]       rs1_data,
    output logic [isa_pkg::DATA_W-1:0]       rs2_data
);

    logic [isa_pkg::DATA_W-1:0] regs [2**isa_pkg::REG_ADDR_W];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wb_we && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // r0 is hardwired, a write in flight is seen by the read
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wb_we && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wb_we && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

endmodule

// ==== hazard_unit.sv ====
// combinational hazard logic: load-use stall for decode and forwarding selects for execute
module hazard_unit (
    input  logic [isa_pkg::REG_ADDR_W-1:0] dec_rs1,
    input  logic [isa_pkg::REG_ADDR_W-1:0] dec_rs2,
    input  logic [isa_pkg::REG_ADDR_W-1:0] ex_rd,
    input  logic                           ex_is_load,
    input  logic [isa_pkg::REG_ADDR_W-1:0] ex_rs1,
    input  logic [isa_pkg::REG_ADDR_W-1:0] ex_rs2,
    input  logic [isa_pkg::REG_ADDR_W-1:0] mem_rd,
    input  logic                           mem_we,
    input  logic [isa_pkg::REG_ADDR_W-1:0] wb_rd,
    input  logic                           wb_we,
    output logic                           stall,
    output pipe_pkg::fwd_sel_e             fwd_a,
    output pipe_pkg::fwd_sel_e             fwd_b
);

    // memory stage is younger than writeback, so it is checked first
    function automatic pipe_pkg::fwd_sel_e pick_source(
        input logic [isa_pkg::REG_ADDR_W-1:0] rs,
        input logic [isa_pkg::REG_ADDR_W-1:0] m_rd,
        input logic                           m_we,
        input logic [isa_pkg::REG_ADDR_W-1:0] w_rd,
        input logic                           w_we
    );
        if (rs == '0) begin
            return pipe_pkg::FWD_RF;
        end
        if (m_we && m_rd == rs) begin
            return pipe_pkg::FWD_MEM;
        end
        if (w_we && w_rd == rs) begin
            return pipe_pkg::FWD_WB;
        end
        return pipe_pkg::FWD_RF;
    endfunction

    assign fwd_a = pick_source(ex_rs1, mem_rd, mem_we, wb_rd, wb_we);
    assign fwd_b = pick_source(ex_rs2, mem_rd, mem_we, wb_rd, wb_we);

    // loaded value exists only after the memory stage
    assign stall = ex_is_load && (ex_rd != '0) && (ex_rd == dec_rs1 || ex_rd == dec_rs2);

endmodule

// ==== fetch_decode.sv ====
// front end of the core: program counter, loadable instruction memory, decode, FD and DE registers
module fetch_decode (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic                              run,
    input  logic                              prog_we,
    input  logic [pipe_pkg::IMEM_ADDR_W-1:0]  prog_addr,
    input  logic [isa_pkg::DATA_W-1:0]        prog_data,
    input  logic                              stall,
    input  logic                              branch_taken,
    input  logic [pipe_pkg::IMEM_ADDR_W-1:0]  branch_target,
    input  logic                              halt_seen,
    input  logic                              wb_we,
    input  logic [isa_pkg::REG_ADDR_W-1:0]    wb_rd,
    input  logic [isa_pkg::DATA_W-1:0]        wb_data,
    output logic [isa_pkg::REG_ADDR_W-1:0]    dec_rs1,
    output logic [isa_pkg::REG_ADDR_W-1:0]    dec_rs2,
    output logic [pipe_pkg::IMEM_ADDR_W-1:0]  ex_pc,
    output isa_pkg::opcode_e                  ex_op,
    output pipe_pkg::alu_op_e                 ex_alu_op,
    output logic [isa_pkg::DATA_W-1:0]        ex_imm,
    output logic [isa_pkg::REG_ADDR_W-1:0]    ex_rd,
    output logic                              ex_we,
    output logic [isa_pkg::REG_ADDR_W-1:0]    ex_rs1,
    output logic [isa_pkg::REG_ADDR_W-1:0]    ex_rs2,
    output logic [isa_pkg::DATA_W-1:0]        ex_a,
    output logic [isa_pkg::DATA_W-1:0]        ex_b
);

    logic [isa_pkg::DATA_W-1:0]              imem [pipe_pkg::IMEM_DEPTH];
    logic [pipe_pkg::IMEM_ADDR_W-1:0]        pc;
    logic                                    stopped;
    logic                                    flush;
    logic                                    fd_valid;
    logic [isa_pkg::DATA_W-1:0]              fd_instr;
    logic [pipe_pkg::IMEM_ADDR_W-1:0]        fd_pc;
    isa_pkg::opcode_e                        dec_op;
    pipe_pkg::alu_op_e                       dec_alu_op;
    logic [isa_pkg::DATA_W-1:0]              dec_imm;
    logic                                    dec_we;
    logic                                    dec_known;
    logic signed [isa_pkg::REG_ADDR_W-1:0]   short_imm;
    logic signed [2*isa_pkg::REG_ADDR_W-1:0] branch_off;
    logic [isa_pkg::DATA_W-1:0]              rs1_data;
    logic [isa_pkg::DATA_W-1:0]              rs2_data;

    assign flush = branch_taken || halt_seen;

    // program load, only while the core is idle
    always_ff @(posedge clock) begin
        if (prog_we && !run) begin
            imem[prog_addr] <= prog_data;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            stopped  <= 1'b0;
            fd_valid <= 1'b0;
        end else begin
            if (halt_seen) begin
                stopped <= 1'b1;
            end
            if (branch_taken) begin
                pc <= branch_target;
            end else if (run && !stopped && !halt_seen && !stall) begin
                pc <= pc + 1'b1;
            end
            if (flush || stopped) begin
                fd_valid <= 1'b0;
            end else if (!stall) begin
                fd_valid <= run;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!stall) begin
            fd_instr <= imem[pc];
            fd_pc    <= pc;
        end
    end

    // an empty slot reads r0 so it never trips the hazard check
    assign dec_rs1 = fd_valid ? fd_instr[isa_pkg::RS1_LSB +: isa_pkg::REG_ADDR_W] : '0;
    assign dec_rs2 = fd_valid ? fd_instr[isa_pkg::RS2_LSB +: isa_pkg::REG_ADDR_W] : '0;

    assign short_imm  = fd_instr[isa_pkg::RS2_LSB +: isa_pkg::REG_ADDR_W];
    assign branch_off = {fd_instr[isa_pkg::RS2_LSB +: isa_pkg::REG_ADDR_W],
                         fd_instr[isa_pkg::RD_LSB +: isa_pkg::REG_ADDR_W]};

    always_comb begin
        dec_op     = isa_pkg::opcode_e'(fd_instr[isa_pkg::OP_LSB +: isa_pkg::OP_W]);
        dec_alu_op = pipe_pkg::ALU_PASS_B;
        dec_imm    = '0;
        dec_we     = 1'b0;
        dec_known  = 1'b1;
        case (dec_op)
            isa_pkg::OP_ADD: begin
                dec_alu_op = pipe_pkg::ALU_ADD;
                dec_we     = 1'b1;
            end
            isa_pkg::OP_SUB: begin
                dec_alu_op = pipe_pkg::ALU_SUB;
                dec_we     = 1'b1;
            end
            isa_pkg::OP_AND: begin
                dec_alu_op = pipe_pkg::ALU_AND;
                dec_we     = 1'b1;
            end
            isa_pkg::OP_OR: begin
                dec_alu_op = pipe_pkg::ALU_OR;
                dec_we     = 1'b1;
            end
            isa_pkg::OP_SLT: begin
                dec_alu_op = pipe_pkg::ALU_SLT;
                dec_we     = 1'b1;
            end
            isa_pkg::OP_ADDI: begin
                dec_alu_op = pipe_pkg::ALU_ADD;
                dec_imm    = short_imm;
                dec_we     = 1'b1;
            end
            // rs1 plus zero gives the load address
            isa_pkg::OP_LW: begin
                dec_alu_op = pipe_pkg::ALU_ADD;
                dec_we     = 1'b1;
            end
            isa_pkg::OP_SW:   dec_alu_op = pipe_pkg::ALU_ADD;
            isa_pkg::OP_IN:   dec_we = 1'b1;
            isa_pkg::OP_OUT:  dec_alu_op = pipe_pkg::ALU_ADD;
            isa_pkg::OP_BEQZ: dec_imm = branch_off;
            isa_pkg::OP_HALT: dec_known = 1'b1;
            default:          dec_known = 1'b0;
        endcase
    end

    register_file u_regs (
        .clock    (clock),
        .rst_n    (rst_n),
        .rs1_addr (dec_rs1),
        .rs2_addr (dec_rs2),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // bubble is a non-writing ADD to r0
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_op     <= isa_pkg::OP_ADD;
            ex_alu_op <= pipe_pkg::ALU_PASS_B;
            ex_we     <= 1'b0;
            ex_rd     <= '0;
        end else if (flush || stall || !fd_valid || !dec_known) begin
            ex_op     <= isa_pkg::OP_ADD;
            ex_alu_op <= pipe_pkg::ALU_PASS_B;
            ex_we     <= 1'b0;
            ex_rd     <= '0;
        end else begin
            ex_op     <= dec_op;
            ex_alu_op <= dec_alu_op;
            ex_we     <= dec_we;
            ex_rd     <= fd_instr[isa_pkg::RD_LSB +: isa_pkg::REG_ADDR_W];
        end
    end

    always_ff @(posedge clock) begin
        ex_pc  <= fd_pc;
        ex_imm <= dec_imm;
        ex_rs1 <= dec_rs1;
        ex_rs2 <= dec_rs2;
        ex_a   <= rs1_data;
        ex_b   <= rs2_data;
    end

endmodule

// ==== execute_stage.sv ====
// execute stage: forwarding muxes, ALU, BEQZ resolution, HALT detect and the EX/MEM register
module execute_stage (
    input  logic                              clock,
    input  logic                              rst_n,
    input  logic [pipe_pkg::IMEM_ADDR_W-1:0]  ex_pc,
    input  isa_pkg::opcode_e                  ex_op,
    input  pipe_pkg::alu_op_e                 ex_alu_op,
    input  logic [isa_pkg::DATA_W-1:0]        ex_imm,
    input  logic [isa_pkg::REG_ADDR_W-1:0]    ex_rd,
    input  logic                              ex_we,
    input  logic [isa_pkg::DATA_W-1:0]        ex_a,
    input  logic [isa_pkg::DATA_W-1:0]        ex_b,
    input  pipe_pkg::fwd_sel_e                fwd_a,
    input  pipe_pkg::fwd_sel_e                fwd_b,
    input  logic [isa_pkg::DATA_W-1:0]        mem_fwd_data,
    input  logic [isa_pkg::DATA_W-1:0]        wb_fwd_data,
    output logic                              branch_taken,
    output logic [pipe_pkg::IMEM_ADDR_W-1:0]  branch_target,
    output logic                              halt_seen,
    output isa_pkg::opcode_e                  mem_op,
    output logic [isa_pkg::REG_ADDR_W-1:0]    mem_rd,
    output logic                              mem_we,
    output logic [isa_pkg::DATA_W-1:0]        mem_result,
    output logic [isa_pkg::DATA_W-1:0]        mem_store_data
);

    logic [isa_pkg::DATA_W-1:0] op_a;
    logic [isa_pkg::DATA_W-1:0] op_b;
    logic [isa_pkg::DATA_W-1:0] alu_b;
    logic [isa_pkg::DATA_W-1:0] alu_y;
    logic                       reg_b;

    function automatic logic [isa_pkg::DATA_W-1:0] fwd_mux(
        input pipe_pkg::fwd_sel_e         sel,
        input logic [isa_pkg::DATA_W-1:0] rf_val,
        input logic [isa_pkg::DATA_W-1:0] mem_val,
        input logic [isa_pkg::DATA_W-1:0] wb_val
    );
        case (sel)
            pipe_pkg::FWD_MEM: return mem_val;
            pipe_pkg::FWD_WB:  return wb_val;
            default:           return rf_val;
        endcase
    endfunction

    assign op_a = fwd_mux(fwd_a, ex_a, mem_fwd_data, wb_fwd_data);
    assign op_b = fwd_mux(fwd_b, ex_b, mem_fwd_data, wb_fwd_data);

    // only the register-register ops take rs2 into the ALU
    assign reg_b = ex_op inside {isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND,
                                 isa_pkg::OP_OR, isa_pkg::OP_SLT};
    assign alu_b = reg_b ? op_b : ex_imm;

    always_comb begin
        alu_y = '0;
        case (ex_alu_op)
            pipe_pkg::ALU_ADD: alu_y = op_a + alu_b;
            pipe_pkg::ALU_SUB: alu_y = op_a - alu_b;
            pipe_pkg::ALU_AND: alu_y = op_a & alu_b;
            pipe_pkg::ALU_OR:  alu_y = op_a | alu_b;
            pipe_pkg::ALU_SLT: alu_y[0] = $signed(op_a) < $signed(alu_b);
            default:           alu_y = alu_b;
        endcase
    end

    assign branch_taken  = (ex_op == isa_pkg::OP_BEQZ) && (op_a == '0);
    assign branch_target = ex_pc + ex_imm[pipe_pkg::IMEM_ADDR_W-1:0];
    assign halt_seen     = (ex_op == isa_pkg::OP_HALT);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mem_op <= isa_pkg::OP_ADD;
            mem_rd <= '0;
            mem_we <= 1'b0;
        end else begin
            mem_op <= ex_op;
            mem_rd <= ex_rd;
            mem_we <= ex_we;
        end
    end

    always_ff @(posedge clock) begin
        mem_result     <= alu_y;
        mem_store_data <= op_b;
    end

endmodule

// ==== memory_writeback.sv ====
// memory and writeback stages: data memory, IN/OUT ports, halt flag and register file write
module memory_writeback (
    input  logic                           clock,
    input  logic                           rst_n,
    input  isa_pkg::opcode_e               mem_op,
    input  logic [isa_pkg::REG_ADDR_W-1:0] mem_rd,
    input  logic                           mem_we,
    input  logic [isa_pkg::DATA_W-1:0]     mem_result,
    input  logic [isa_pkg::DATA_W-1:0]     mem_store_data,
    input  logic [isa_pkg::DATA_W-1:0]     read_in,
    output logic [isa_pkg::DATA_W-1:0]     write_out,
    output logic                           out_valid,
    output logic                           halted,
    output logic [isa_pkg::DATA_W-1:0]     mem_fwd_data,
    output logic                           wb_we,
    output logic [isa_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [isa_pkg::DATA_W-1:0]     wb_data
);

    logic [isa_pkg::DATA_W-1:0]       dmem [pipe_pkg::DMEM_DEPTH];
    logic [pipe_pkg::DMEM_ADDR_W-1:0] dmem_addr;
    logic [isa_pkg::DATA_W-1:0]       stage_value;

    assign dmem_addr = mem_result[pipe_pkg::DMEM_ADDR_W-1:0];

    always_ff @(posedge clock) begin
        if (mem_op == isa_pkg::OP_SW) begin
            dmem[dmem_addr] <= mem_store_data;
        end
    end

    // value this stage hands to writeback, also forwarded into execute
    always_comb begin
        case (mem_op)
            isa_pkg::OP_LW: stage_value = dmem[dmem_addr];
            isa_pkg::OP_IN: stage_value = read_in;
            default:        stage_value = mem_result;
        endcase
    end

    assign mem_fwd_data = stage_value;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb_we     <= 1'b0;
            wb_rd     <= '0;
            out_valid <= 1'b0;
            write_out <= '0;
            halted    <= 1'b0;
        end else begin
            wb_we     <= mem_we;
            wb_rd     <= mem_rd;
            out_valid <= (mem_op == isa_pkg::OP_OUT);
            if (mem_op == isa_pkg::OP_OUT) begin
                write_out <= mem_result;
            end
            // sticky until reset
            if (mem_op == isa_pkg::OP_HALT) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        wb_data <= stage_value;
    end

endmodule

// ==== load_store_core.sv ====
// top level of the five-stage load-store core, connecting front end, hazard unit and back end
module load_store_core (
    input  logic                             clock,
    input  logic                             rst_n,
    input  logic                             run,
    input  logic                             prog_we,
    input  logic [pipe_pkg::IMEM_ADDR_W-1:0] prog_addr,
    input  logic [isa_pkg::DATA_W-1:0]       prog_data,
    input  logic [isa_pkg::DATA_W-1:0]       read_in,
    output logic [isa_pkg::DATA_W-1:0]       write_out,
    output logic                             out_valid,
    output logic                             halted
);

    logic                             stall;
    logic                             branch_taken;
    logic [pipe_pkg::IMEM_ADDR_W-1:0] branch_target;
    logic                             halt_seen;
    logic [isa_pkg::REG_ADDR_W-1:0]   dec_rs1;
    logic [isa_pkg::REG_ADDR_W-1:0]   dec_rs2;
    logic [pipe_pkg::IMEM_ADDR_W-1:0] ex_pc;
    isa_pkg::opcode_e                 ex_op;
    pipe_pkg::alu_op_e                ex_alu_op;
    logic [isa_pkg::DATA_W-1:0]       ex_imm;
    logic [isa_pkg::REG_ADDR_W-1:0]   ex_rd;
    logic                             ex_we;
    logic [isa_pkg::REG_ADDR_W-1:0]   ex_rs1;
    logic [isa_pkg::REG_ADDR_W-1:0]   ex_rs2;
    logic [isa_pkg::DATA_W-1:0]       ex_a;
    logic [isa_pkg::DATA_W-1:0]       ex_b;
    pipe_pkg::fwd_sel_e               fwd_a;
    pipe_pkg::fwd_sel_e               fwd_b;
    isa_pkg::opcode_e                 mem_op;
    logic [isa_pkg::REG_ADDR_W-1:0]   mem_rd;
    logic                             mem_we;
    logic [isa_pkg::DATA_W-1:0]       mem_result;
    logic [isa_pkg::DATA_W-1:0]       mem_store_data;
    logic [isa_pkg::DATA_W-1:0]       mem_fwd_data;
    logic                             wb_we;
    logic [isa_pkg::REG_ADDR_W-1:0]   wb_rd;
    logic [isa_pkg::DATA_W-1:0]       wb_data;

    fetch_decode u_fetch_decode (
        .clock         (clock),
        .rst_n         (rst_n),
        .run           (run),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .halt_seen     (halt_seen),
        .wb_we         (wb_we),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .dec_rs1       (dec_rs1),
        .dec_rs2       (dec_rs2),
        .ex_pc         (ex_pc),
        .ex_op         (ex_op),
        .ex_alu_op     (ex_alu_op),
        .ex_imm        (ex_imm),
        .ex_rd         (ex_rd),
        .ex_we         (ex_we),
        .ex_rs1        (ex_rs1),
        .ex_rs2        (ex_rs2),
        .ex_a          (ex_a),
        .ex_b          (ex_b)
    );

    hazard_unit u_hazard (
        .dec_rs1    (dec_rs1),
        .dec_rs2    (dec_rs2),
        .ex_rd      (ex_rd),
        .ex_is_load (ex_op == isa_pkg::OP_LW),
        .ex_rs1     (ex_rs1),
        .ex_rs2     (ex_rs2),
        .mem_rd     (mem_rd),
        .mem_we     (mem_we),
        .wb_rd      (wb_rd),
        .wb_we      (wb_we),
        .stall      (stall),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b)
    );

    execute_stage u_execute (
        .clock          (clock),
        .rst_n          (rst_n),
        .ex_pc          (ex_pc),
        .ex_op          (ex_op),
        .ex_alu_op      (ex_alu_op),
        .ex_imm         (ex_imm),
        .ex_rd          (ex_rd),
        .ex_we          (ex_we),
        .ex_a           (ex_a),
        .ex_b           (ex_b),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .mem_fwd_data   (mem_fwd_data),
        .wb_fwd_data    (wb_data),
        .branch_taken   (branch_taken),
        .branch_target  (branch_target),
        .halt_seen      (halt_seen),
        .mem_op         (mem_op),
        .mem_rd         (mem_rd),
        .mem_we         (mem_we),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data)
    );

    memory_writeback u_memory_writeback (
        .clock          (clock),
        .rst_n          (rst_n),
        .mem_op         (mem_op),
        .mem_rd         (mem_rd),
        .mem_we         (mem_we),
        .mem_result     (mem_result),
        .mem_store_data (mem_store_data),
        .read_in        (read_in),
        .write_out      (write_out),
        .out_valid      (out_valid),
        .halted         (halted),
        .mem_fwd_data   (mem_fwd_data),
        .wb_we          (wb_we),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

endmodule

// ==== tb_clock_gen.sv ====
// testbench clock and reset source, 4-unit clock period with reset held low for two rising edges
module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

// ==== load_store_core_chk.sv ====
// port assertions for the load-store core, attached to every core instance by the bind below
module load_store_core_chk (
    input logic                       clock,
    input logic                       rst_n,
    input logic [isa_pkg::DATA_W-1:0] write_out,
    input logic                       out_valid,
    input logic                       halted
);

    // read by the testbench to end the run early
    int fail_count = 0;

    // sticky until the next reset
    halted_stays_high: assert property (
        @(posedge clock) disable iff (!rst_n) halted |=> halted
    ) else begin
        fail_count++;
        $error("halted dropped without a reset");
    end

    no_output_after_halt: assert property (
        @(posedge clock) disable iff (!rst_n) halted |=> !out_valid
    ) else begin
        fail_count++;
        $error("out_valid pulsed after the core had halted");
    end

    outputs_known: assert property (
        @(posedge clock) disable iff (!rst_n) !$isunknown({write_out, out_valid, halted})
    ) else begin
        fail_count++;
        $error("a top-level output is unknown after reset");
    end

endmodule

bind load_store_core load_store_core_chk u_port_chk (
    .clock     (clock),
    .rst_n     (rst_n),
    .write_out (write_out),
    .out_valid (out_valid),
    .halted    (halted)
);

// ==== load_store_core_tb.sv ====
// testbench for the load-store core: loads the program from program_input.txt, runs it, checks OUT values
module load_store_core_tb;

    localparam int RESET_TIMEOUT = 20;
    localparam int RUN_TIMEOUT   = 2000;
    localparam int DRAIN_CYCLES  = 8;
    localparam int EOF_CHAR      = -1;

    logic                             clock;
    logic                             rst_n;
    logic                             run;
    logic                             prog_we;
    logic [pipe_pkg::IMEM_ADDR_W-1:0] prog_addr;
    logic [isa_pkg::DATA_W-1:0]       prog_data;
    logic [isa_pkg::DATA_W-1:0]       read_in;
    logic [isa_pkg::DATA_W-1:0]       write_out;
    logic                             out_valid;
    logic                             halted;

    int                               prog_addrs [$];
    logic [isa_pkg::DATA_W-1:0]       prog_words [$];
    logic [isa_pkg::DATA_W-1:0]       expected [$];
    logic [isa_pkg::DATA_W-1:0]       observed [$];
    logic [isa_pkg::DATA_W-1:0]       in_value;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    load_store_core load_store_core_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .run       (run),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .read_in   (read_in),
        .write_out (write_out),
        .out_valid (out_valid),
        .halted    (halted)
    );

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] wanted);
        if (actual !== wanted) begin
            $display("[FAIL] time %0t: %s is %0h, expected %0h", $time, what, actual, wanted);
            abort_run();
        end
    endtask

    // HALT everywhere, with the address in the unused rd/rs1 bits
    function automatic logic [isa_pkg::DATA_W-1:0] fill_word(input int addr);
        return {6'b0, addr[pipe_pkg::IMEM_ADDR_W-1:0], 4'hb};
    endfunction

    task automatic read_stimulus();
        int                         fd;
        int                         c;
        int                         n;
        int                         addr;
        logic [isa_pkg::DATA_W-1:0] value;
        fd = $fopen("program_input.txt", "r");
        if (fd == 0) begin
            $display("could not open program_input.txt for reading");
            abort_run();
        end
        in_value = '0;
        c = $fgetc(fd);
        while (c != EOF_CHAR) begin
            if (c == "#") begin
                while (c != EOF_CHAR && c != "\n") begin
                    c = $fgetc(fd);
                end
            end else if (c == "P") begin
                n = $fscanf(fd, "%h %h", addr, value);
                if (n != 2 || addr < 0 || addr >= pipe_pkg::IMEM_DEPTH) begin
                    $display("bad program line in program_input.txt");
                    abort_run();
                end
                prog_addrs.push_back(addr);
                prog_words.push_back(value);
            end else if (c == "R" || c == "E") begin
                n = $fscanf(fd, "%h", value);
                if (n != 1) begin
                    $display("missing value after R or E in program_input.txt");
                    abort_run();
                end
                if (c == "R") begin
                    in_value = value;
                end else begin
                    expected.push_back(value);
                end
            end else if (c != " " && c != "\t" && c != "\n" && c != "\r") begin
                $display("unexpected character in program_input.txt");
                abort_run();
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clock);
            cycles++;
            if (cycles > RESET_TIMEOUT && rst_n !== 1'b1) begin
                $display("reset was never released");
                abort_run();
            end
        end
    endtask

    task automatic write_imem_word(input int addr, input logic [isa_pkg::DATA_W-1:0] word);
        @(posedge clock);
        prog_we   <= 1'b1;
        prog_addr <= addr[pipe_pkg::IMEM_ADDR_W-1:0];
        prog_data <= word;
    endtask

    task automatic load_program();
        // fetches past HALT then read a defined word
        for (int a = 0; a < pipe_pkg::IMEM_DEPTH; a++) begin
            write_imem_word(a, fill_word(a));
        end
        foreach (prog_addrs[i]) begin
            write_imem_word(prog_addrs[i], prog_words[i]);
        end
        @(posedge clock);
        prog_we <= 1'b0;
    endtask

    task automatic collect_outputs();
        int cycles;
        cycles = 0;
        while (halted !== 1'b1) begin
            @(negedge clock);
            if (out_valid === 1'b1) begin
                observed.push_back(write_out);
            end
            cycles++;
            if (cycles >= RUN_TIMEOUT && halted !== 1'b1) begin
                $display("halted never rose within %0d cycles after run", RUN_TIMEOUT);
                abort_run();
            end
        end
        // a few more cycles so a stray OUT after HALT is caught
        repeat (DRAIN_CYCLES) begin
            @(negedge clock);
            if (out_valid === 1'b1) begin
                observed.push_back(write_out);
            end
        end
    endtask

    always @(negedge clock) begin
        if (load_store_core_i.u_port_chk.fail_count != 0) begin
            $display("a port assertion on the DUT failed");
            abort_run();
        end
    end

    initial begin
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        read_in   = '0;
        read_stimulus();
        wait_for_reset();
        load_program();
        @(posedge clock);
        read_in <= in_value;
        run     <= 1'b1;
        collect_outputs();
        foreach (expected[i]) begin
            if (i < observed.size()) begin
                check_value($sformatf("output %0d", i), observed[i], expected[i]);
            end
        end
        check_value("output count", observed.size(), expected.size());
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== load_store_core.f ====
isa_pkg.sv
pipe_pkg.sv
register_file.sv
hazard_unit.sv
fetch_decode.sv
execute_stage.sv
memory_writeback.sv
load_store_core.sv
tb_clock_gen.sv
load_store_core_chk.sv
load_store_core_tb.sv

// ==== Makefile ====
# Verilator build and run for the load-store core testbench

VERILATOR   ?= verilator
TOP         ?= load_store_core_tb
FILELIST    ?= load_store_core.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
SIM_ARGS    ?= +verilator+error+limit+100
PASS_MSG    ?= Simulation finished: PASS

SIM_BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES     = $(filter %.sv %.v,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== program_input.txt ====
# P <imem address> <instruction word>, R <read_in value>, E <next expected write_out>, all hex
# word layout {rs2, rs1, rd, op}, text after # is ignored
R 1234
# ALU results
P 00 7015  # ADDI r1, r0, 7
P 01 3025  # ADDI r2, r0, 3
P 02 E035  # ADDI r3, r0, -2
P 03 2140  # ADD r4, r1, r2
P 04 0409  # OUT r4
P 05 1251  # SUB r5, r2, r1
P 06 0509  # OUT r5
P 07 3162  # AND r6, r1, r3
P 08 0609  # OUT r6
P 09 3273  # OR r7, r2, r3
P 0A 0709  # OUT r7
P 0B 1384  # SLT r8, r3, r1
P 0C 3194  # SLT r9, r1, r3
P 0D 0809  # OUT r8
P 0E 0909  # OUT r9
# dependent chains at distance 1, 2 and 3
P 0F 51A5  # ADDI r10, r1, 5
P 10 AAB0  # ADD r11, r10, r10
P 11 BAC0  # ADD r12, r10, r11
P 12 CAD0  # ADD r13, r10, r12
P 13 0D09  # OUT r13
P 14 BDE1  # SUB r14, r13, r11
P 15 0E09  # OUT r14
P 16 10F5  # ADDI r15, r0, 1
P 17 2FF5  # ADDI r15, r15, 2
P 18 0F09  # OUT r15, memory stage beats writeback
# store, load and load-use
P 19 5015  # ADDI r1, r0, 5
P 1A E107  # SW r14, [r1]
P 1B 0126  # LW r2, [r1]
P 1C 2230  # ADD r3, r2, r2
P 1D 0309  # OUT r3
P 1E 0146  # LW r4, [r1]
P 1F 0409  # OUT r4
# branches
P 20 003A  # BEQZ r0, +3 taken
P 21 0109  # OUT r1 skipped
P 22 0209  # OUT r2 skipped
P 23 013A  # BEQZ r1, +3 not taken
P 24 0109  # OUT r1
P 25 1151  # SUB r5, r1, r1
P 26 053A  # BEQZ r5, +3 taken
P 27 0209  # OUT r2 skipped
P 28 0309  # OUT r3 skipped
# input port and halt
P 29 0068  # IN r6
P 2A 1675  # ADDI r7, r6, 1
P 2B 0709  # OUT r7
P 2C 0609  # OUT r6
P 2D 000B  # HALT
P 2E 0109  # OUT r1 never runs
P 2F 0209  # OUT r2 never runs
E 000A
E FFFC
E 0006
E FFFF
E 0001
E 0000
E 0030
E 0018
E 0003
E 0030
E 0018
E 0005
E 1235
E 1234
